// ==== Bender.yml ====
package:
  name: be_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/be_pkg.sv
      - rtl/rename_stage.sv
      - rtl/execute_stage.sv
      - rtl/reorder_buffer.sv
      - rtl/commit_stage.sv
      - rtl/be_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_be_top.sv

// ==== flist.f ====
+incdir+rtl
rtl/be_pkg.sv
rtl/rename_stage.sv
rtl/execute_stage.sv
rtl/reorder_buffer.sv
rtl/commit_stage.sv
rtl/be_top.sv
test/tb_be_top.sv

// ==== rtl/be_config.svh ====
`ifndef BE_CONFIG_SVH
`define BE_CONFIG_SVH

// data path width in bits
`define BE_WORD_W 32

// architectural registers with r0 hardwired to zero
`define BE_NUM_ARCH_REG 8

// reorder buffer depth as a power of two so tags wrap naturally
`define BE_ROB_ENTRY 8

// multiply lane depth of at least 2
`define BE_MUL_LAT 3

`endif

// ==== rtl/be_pkg.sv ====
`include "be_config.svh"

package be_pkg;

  // op encoding shared by decode and the execute lanes
  typedef enum logic [1:0]
  {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_MUL = 2'd3
  } op_e;

  typedef logic [$clog2(`BE_NUM_ARCH_REG)-1:0] arch_reg_t;
  typedef logic [$clog2(`BE_ROB_ENTRY)-1:0]    rob_tag_t;

  // register form with two register sources
  typedef struct packed {
    op_e       op;
    arch_reg_t rd;
    arch_reg_t rs1;
    arch_reg_t rs2;
    logic [4:0] pad;
  } reg_form_t;

  // immediate form whose imm is sign extended to a word
  typedef struct packed {
    op_e        op;
    arch_reg_t  rd;
    arch_reg_t  rs1;
    logic [7:0] imm;
  } imm_form_t;

  // decoded word whose view is picked by the separate is_imm bit
  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } instr_u;

endpackage

// ==== rtl/be_top.sv ====
`include "be_config.svh"

module be_top
( input  logic                   clk_i
, input  logic                   rst_n_i
, input  be_pkg::instr_u         instr_i
, input  logic                   instr_imm_i
, input  logic                   instr_v_i
, output logic                   instr_ready_o
, output logic                   commit_v_o
, output be_pkg::arch_reg_t      commit_rd_o
, output logic [`BE_WORD_W-1:0]  commit_data_o
);

  // rename <-> rob allocation
  logic                  alloc_v;
  be_pkg::arch_reg_t     alloc_rd;
  logic                  alloc_ready;
  be_pkg::rob_tag_t      alloc_tag;

  // rename -> execute
  logic                  dispatch_v;
  be_pkg::op_e           dispatch_op;
  be_pkg::rob_tag_t      dispatch_tag;
  logic [`BE_WORD_W-1:0] dispatch_a;
  logic [`BE_WORD_W-1:0] dispatch_b;

  // operand reads from commit and rob
  be_pkg::arch_reg_t     rs1_addr;
  be_pkg::arch_reg_t     rs2_addr;
  logic [`BE_WORD_W-1:0] rs1_data;
  logic [`BE_WORD_W-1:0] rs2_data;
  be_pkg::rob_tag_t      fwd1_tag;
  be_pkg::rob_tag_t      fwd2_tag;
  logic                  fwd1_done;
  logic                  fwd2_done;
  logic [`BE_WORD_W-1:0] fwd1_data;
  logic [`BE_WORD_W-1:0] fwd2_data;

  // writeback lanes
  logic                  alu_wb_v;
  be_pkg::rob_tag_t      alu_wb_tag;
  logic [`BE_WORD_W-1:0] alu_wb_data;
  logic                  mul_wb_v;
  be_pkg::rob_tag_t      mul_wb_tag;
  logic [`BE_WORD_W-1:0] mul_wb_data;

  // retirement as seen by commit and the alias table
  logic                  retire_v;
  be_pkg::arch_reg_t     retire_rd;
  logic [`BE_WORD_W-1:0] retire_data;
  be_pkg::rob_tag_t      retire_tag;

  rename_stage u_rename
  ( .clk_i          (clk_i)
  , .rst_n_i        (rst_n_i)
  , .instr_i        (instr_i)
  , .instr_imm_i    (instr_imm_i)
  , .instr_v_i      (instr_v_i)
  , .instr_ready_o  (instr_ready_o)
  , .alloc_ready_i  (alloc_ready)
  , .alloc_tag_i    (alloc_tag)
  , .alloc_v_o      (alloc_v)
  , .alloc_rd_o     (alloc_rd)
  , .rs1_addr_o     (rs1_addr)
  , .rs2_addr_o     (rs2_addr)
  , .rs1_data_i     (rs1_data)
  , .rs2_data_i     (rs2_data)
  , .fwd1_tag_o     (fwd1_tag)
  , .fwd2_tag_o     (fwd2_tag)
  , .fwd1_done_i    (fwd1_done)
  , .fwd1_data_i    (fwd1_data)
  , .fwd2_done_i    (fwd2_done)
  , .fwd2_data_i    (fwd2_data)
  , .retire_v_i     (retire_v)
  , .retire_rd_i    (retire_rd)
  , .retire_tag_i   (retire_tag)
  , .dispatch_v_o   (dispatch_v)
  , .dispatch_op_o  (dispatch_op)
  , .dispatch_tag_o (dispatch_tag)
  , .dispatch_a_o   (dispatch_a)
  , .dispatch_b_o   (dispatch_b)
  );

  execute_stage u_execute
  ( .clk_i          (clk_i)
  , .rst_n_i        (rst_n_i)
  , .dispatch_v_i   (dispatch_v)
  , .dispatch_op_i  (dispatch_op)
  , .dispatch_tag_i (dispatch_tag)
  , .dispatch_a_i   (dispatch_a)
  , .dispatch_b_i   (dispatch_b)
  , .alu_wb_v_o     (alu_wb_v)
  , .alu_wb_tag_o   (alu_wb_tag)
  , .alu_wb_data_o  (alu_wb_data)
  , .mul_wb_v_o     (mul_wb_v)
  , .mul_wb_tag_o   (mul_wb_tag)
  , .mul_wb_data_o  (mul_wb_data)
  );

  reorder_buffer u_rob
  ( .clk_i          (clk_i)
  , .rst_n_i        (rst_n_i)
  , .alloc_v_i      (alloc_v)
  , .alloc_rd_i     (alloc_rd)
  , .alloc_ready_o  (alloc_ready)
  , .alloc_tag_o    (alloc_tag)
  , .alu_wb_v_i     (alu_wb_v)
  , .alu_wb_tag_i   (alu_wb_tag)
  , .alu_wb_data_i  (alu_wb_data)
  , .mul_wb_v_i     (mul_wb_v)
  , .mul_wb_tag_i   (mul_wb_tag)
  , .mul_wb_data_i  (mul_wb_data)
  , .fwd1_tag_i     (fwd1_tag)
  , .fwd2_tag_i     (fwd2_tag)
  , .fwd1_done_o    (fwd1_done)
  , .fwd1_data_o    (fwd1_data)
  , .fwd2_done_o    (fwd2_done)
  , .fwd2_data_o    (fwd2_data)
  , .retire_v_o     (retire_v)
  , .retire_rd_o    (retire_rd)
  , .retire_data_o  (retire_data)
  , .retire_tag_o   (retire_tag)
  );

  commit_stage u_commit
  ( .clk_i          (clk_i)
  , .rst_n_i        (rst_n_i)
  , .retire_v_i     (retire_v)
  , .retire_rd_i    (retire_rd)
  , .retire_data_i  (retire_data)
  , .rs1_addr_i     (rs1_addr)
  , .rs2_addr_i     (rs2_addr)
  , .rs1_data_o     (rs1_data)
  , .rs2_data_o     (rs2_data)
  , .commit_v_o     (commit_v_o)
  , .commit_rd_o    (commit_rd_o)
  , .commit_data_o  (commit_data_o)
  );

endmodule

// ==== rtl/commit_stage.sv ====
`include "be_config.svh"

module commit_stage
( input  logic                   clk_i
, input  logic                   rst_n_i
, input  logic                   retire_v_i
, input  be_pkg::arch_reg_t      retire_rd_i
, input  logic [`BE_WORD_W-1:0]  retire_data_i
, input  be_pkg::arch_reg_t      rs1_addr_i
, input  be_pkg::arch_reg_t      rs2_addr_i
, output logic [`BE_WORD_W-1:0]  rs1_data_o
, output logic [`BE_WORD_W-1:0]  rs2_data_o
, output logic                   commit_v_o
, output be_pkg::arch_reg_t      commit_rd_o
, output logic [`BE_WORD_W-1:0]  commit_data_o
);

  // committed architectural state
  logic [`BE_WORD_W-1:0] rf_q [`BE_NUM_ARCH_REG];

  // r0 always reads zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : rf_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : rf_q[rs2_addr_i];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `BE_NUM_ARCH_REG; i++)
      begin
        rf_q[i] <= '0;
      end
      commit_v_o <= 1'b0;
    end
    else
    begin
      if (retire_v_i && (retire_rd_i != '0))
      begin
        rf_q[retire_rd_i] <= retire_data_i;
      end
      commit_v_o <= retire_v_i;
    end
  end

  // retirement report one cycle behind the rob head
  always_ff @(posedge clk_i)
  begin
    commit_rd_o   <= retire_rd_i;
    commit_data_o <= retire_data_i;
  end

  a_commit_v_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(commit_v_o));

endmodule

// ==== rtl/execute_stage.sv ====
`include "be_config.svh"

module execute_stage
( input  logic                   clk_i
, input  logic                   rst_n_i
, input  logic                   dispatch_v_i
, input  be_pkg::op_e            dispatch_op_i
, input  be_pkg::rob_tag_t       dispatch_tag_i
, input  logic [`BE_WORD_W-1:0]  dispatch_a_i
, input  logic [`BE_WORD_W-1:0]  dispatch_b_i
, output logic                   alu_wb_v_o
, output be_pkg::rob_tag_t       alu_wb_tag_o
, output logic [`BE_WORD_W-1:0]  alu_wb_data_o
, output logic                   mul_wb_v_o
, output be_pkg::rob_tag_t       mul_wb_tag_o
, output logic [`BE_WORD_W-1:0]  mul_wb_data_o
);

  localparam int unsigned LAT = `BE_MUL_LAT;

  logic                  is_mul;
  logic [`BE_WORD_W-1:0] alu_res;
  logic [`BE_WORD_W-1:0] mul_lo;

  logic                  alu_v_q;
  be_pkg::rob_tag_t      alu_tag_q;
  logic [`BE_WORD_W-1:0] alu_data_q;

  // multiply shift pipeline with the product formed in the first stage
  logic [LAT-1:0]        mul_v_q;
  be_pkg::rob_tag_t      mul_tag_q [LAT];
  logic [`BE_WORD_W-1:0] mul_data_q [LAT];

  assign is_mul = (dispatch_op_i == be_pkg::OP_MUL);
  // only the low word is kept
  assign mul_lo = dispatch_a_i * dispatch_b_i;

  always_comb
  begin
    case (dispatch_op_i)
      be_pkg::OP_ADD: alu_res = dispatch_a_i + dispatch_b_i;
      be_pkg::OP_SUB: alu_res = dispatch_a_i - dispatch_b_i;
      be_pkg::OP_XOR: alu_res = dispatch_a_i ^ dispatch_b_i;
      default:        alu_res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      alu_v_q <= 1'b0;
      mul_v_q <= '0;
    end
    else
    begin
      alu_v_q <= dispatch_v_i && !is_mul;
      mul_v_q <= {mul_v_q[LAT-2:0], dispatch_v_i && is_mul};
    end
  end

  always_ff @(posedge clk_i)
  begin
    alu_tag_q     <= dispatch_tag_i;
    alu_data_q    <= alu_res;
    mul_tag_q[0]  <= dispatch_tag_i;
    mul_data_q[0] <= mul_lo;
    for (int i = 1; i < LAT; i++)
    begin
      mul_tag_q[i]  <= mul_tag_q[i-1];
      mul_data_q[i] <= mul_data_q[i-1];
    end
  end

  assign alu_wb_v_o    = alu_v_q;
  assign alu_wb_tag_o  = alu_tag_q;
  assign alu_wb_data_o = alu_data_q;
  assign mul_wb_v_o    = mul_v_q[LAT-1];
  assign mul_wb_tag_o  = mul_tag_q[LAT-1];
  assign mul_wb_data_o = mul_data_q[LAT-1];

  // lanes may collide in time but never on the same rob entry
  a_wb_tags_differ: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (alu_wb_v_o && mul_wb_v_o) |-> (alu_wb_tag_o != mul_wb_tag_o));

endmodule

// ==== rtl/rename_stage.sv ====
`include "be_config.svh"

module rename_stage
( input  logic                   clk_i
, input  logic                   rst_n_i
, input  be_pkg::instr_u         instr_i
, input  logic                   instr_imm_i
, input  logic                   instr_v_i
, output logic                   instr_ready_o
, input  logic                   alloc_ready_i
, input  be_pkg::rob_tag_t       alloc_tag_i
, output logic                   alloc_v_o
, output be_pkg::arch_reg_t      alloc_rd_o
, output be_pkg::arch_reg_t      rs1_addr_o
, output be_pkg::arch_reg_t      rs2_addr_o
, input  logic [`BE_WORD_W-1:0]  rs1_data_i
, input  logic [`BE_WORD_W-1:0]  rs2_data_i
, output be_pkg::rob_tag_t       fwd1_tag_o
, output be_pkg::rob_tag_t       fwd2_tag_o
, input  logic                   fwd1_done_i
, input  logic [`BE_WORD_W-1:0]  fwd1_data_i
, input  logic                   fwd2_done_i
, input  logic [`BE_WORD_W-1:0]  fwd2_data_i
, input  logic                   retire_v_i
, input  be_pkg::arch_reg_t      retire_rd_i
, input  be_pkg::rob_tag_t       retire_tag_i
, output logic                   dispatch_v_o
, output be_pkg::op_e            dispatch_op_o
, output be_pkg::rob_tag_t       dispatch_tag_o
, output logic [`BE_WORD_W-1:0]  dispatch_a_o
, output logic [`BE_WORD_W-1:0]  dispatch_b_o
);

  // alias table with one busy bit and pending tag per register
  logic [`BE_NUM_ARCH_REG-1:0] busy_q;
  be_pkg::rob_tag_t            tag_q [`BE_NUM_ARCH_REG];

  be_pkg::arch_reg_t     rd;
  be_pkg::arch_reg_t     rs1;
  be_pkg::arch_reg_t     rs2;
  logic [`BE_WORD_W-1:0] imm_ext;
  logic                  src1_ok;
  logic                  src2_ok;
  logic                  accept;

  // rd and rs1 sit at the same bits in both views
  assign rd      = instr_i.reg_form.rd;
  assign rs1     = instr_i.reg_form.rs1;
  assign rs2     = instr_i.reg_form.rs2;
  assign imm_ext = {{(`BE_WORD_W-8){instr_i.imm_form.imm[7]}}, instr_i.imm_form.imm};

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;
  assign fwd1_tag_o = tag_q[rs1];
  assign fwd2_tag_o = tag_q[rs2];

  // source usable from the file, or from a finished rob entry
  assign src1_ok = !busy_q[rs1] || fwd1_done_i;
  assign src2_ok = instr_imm_i || !busy_q[rs2] || fwd2_done_i;

  assign instr_ready_o = alloc_ready_i && src1_ok && src2_ok;
  assign accept        = instr_v_i && instr_ready_o;

  assign alloc_v_o      = accept;
  assign alloc_rd_o     = rd;
  assign dispatch_v_o   = accept;
  assign dispatch_op_o  = instr_i.reg_form.op;
  assign dispatch_tag_o = alloc_tag_i;
  assign dispatch_a_o   = busy_q[rs1] ? fwd1_data_i : rs1_data_i;
  assign dispatch_b_o   = instr_imm_i ? imm_ext :
                          (busy_q[rs2] ? fwd2_data_i : rs2_data_i);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_q <= '0;
    end
    else
    begin
      // retirement frees the mapping only if no newer writer took it
      if (retire_v_i && (tag_q[retire_rd_i] == retire_tag_i))
      begin
        busy_q[retire_rd_i] <= 1'b0;
      end
      // new mapping wins over a same cycle clear
      if (accept && (rd != '0))
      begin
        busy_q[rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept && (rd != '0))
    begin
      tag_q[rd] <= alloc_tag_i;
    end
  end

  // a retiring writer still holds its register busy
  a_retire_rd_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (retire_v_i && (retire_rd_i != '0)) |-> busy_q[retire_rd_i]);

endmodule

// ==== rtl/reorder_buffer.sv ====
`include "be_config.svh"

module reorder_buffer
( input  logic                   clk_i
, input  logic                   rst_n_i
, input  logic                   alloc_v_i
, input  be_pkg::arch_reg_t      alloc_rd_i
, output logic                   alloc_ready_o
, output be_pkg::rob_tag_t       alloc_tag_o
, input  logic                   alu_wb_v_i
, input  be_pkg::rob_tag_t       alu_wb_tag_i
, input  logic [`BE_WORD_W-1:0]  alu_wb_data_i
, input  logic                   mul_wb_v_i
, input  be_pkg::rob_tag_t       mul_wb_tag_i
, input  logic [`BE_WORD_W-1:0]  mul_wb_data_i
, input  be_pkg::rob_tag_t       fwd1_tag_i
, input  be_pkg::rob_tag_t       fwd2_tag_i
, output logic                   fwd1_done_o
, output logic [`BE_WORD_W-1:0]  fwd1_data_o
, output logic                   fwd2_done_o
, output logic [`BE_WORD_W-1:0]  fwd2_data_o
, output logic                   retire_v_o
, output be_pkg::arch_reg_t      retire_rd_o
, output logic [`BE_WORD_W-1:0]  retire_data_o
, output be_pkg::rob_tag_t       retire_tag_o
);

  localparam int unsigned CNT_W = $clog2(`BE_ROB_ENTRY) + 1;

  be_pkg::rob_tag_t        head_q;
  be_pkg::rob_tag_t        tail_q;
  logic [CNT_W-1:0]        count_q;
  logic [`BE_ROB_ENTRY-1:0] done_q;
  be_pkg::arch_reg_t       rd_q [`BE_ROB_ENTRY];
  logic [`BE_WORD_W-1:0]   data_q [`BE_ROB_ENTRY];

  logic alloc;
  logic retire;

  // {done, data} of an entry including any writeback landing this cycle
  function automatic logic [`BE_WORD_W:0] lookup(be_pkg::rob_tag_t tag);
    logic [`BE_WORD_W:0] res;
    res = {done_q[tag], data_q[tag]};
    if (mul_wb_v_i && (mul_wb_tag_i == tag))
    begin
      res = {1'b1, mul_wb_data_i};
    end
    if (alu_wb_v_i && (alu_wb_tag_i == tag))
    begin
      res = {1'b1, alu_wb_data_i};
    end
    return res;
  endfunction

  // tag lies between head and tail
  function automatic logic in_use(be_pkg::rob_tag_t tag);
    be_pkg::rob_tag_t off;
    off = tag - head_q;
    return CNT_W'(off) < count_q;
  endfunction

  assign alloc_ready_o = (count_q != CNT_W'(`BE_ROB_ENTRY));
  assign alloc_tag_o   = tail_q;
  assign alloc         = alloc_v_i && alloc_ready_o;

  assign retire_v_o    = (count_q != '0) && done_q[head_q];
  assign retire_rd_o   = rd_q[head_q];
  assign retire_data_o = data_q[head_q];
  assign retire_tag_o  = head_q;
  assign retire        = retire_v_o;

  always_comb
  begin
    {fwd1_done_o, fwd1_data_o} = lookup(fwd1_tag_i);
    {fwd2_done_o, fwd2_data_o} = lookup(fwd2_tag_i);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end
    else
    begin
      if (alloc)
      begin
        tail_q         <= tail_q + 1'b1;
        done_q[tail_q] <= 1'b0;
      end
      if (alu_wb_v_i)
      begin
        done_q[alu_wb_tag_i] <= 1'b1;
      end
      if (mul_wb_v_i)
      begin
        done_q[mul_wb_tag_i] <= 1'b1;
      end
      if (retire)
      begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(alloc) - CNT_W'(retire);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (alloc)
    begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (alu_wb_v_i)
    begin
      data_q[alu_wb_tag_i] <= alu_wb_data_i;
    end
    if (mul_wb_v_i)
    begin
      data_q[mul_wb_tag_i] <= mul_wb_data_i;
    end
  end

  a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc_v_i |-> alloc_ready_o);

  a_alu_wb_live: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alu_wb_v_i |-> in_use(alu_wb_tag_i));

  a_mul_wb_live: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mul_wb_v_i |-> in_use(mul_wb_tag_i));

endmodule

// ==== test/tb_be_top.sv ====
`include "be_config.svh"

module tb_be_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned N_INSTR     = 300;
  localparam int unsigned TIMEOUT_CYC = N_INSTR * (`BE_MUL_LAT + 4) + 100;

  logic                  clk_i;
  logic                  rst_n_i;
  be_pkg::instr_u        instr_i;
  logic                  instr_imm_i;
  logic                  instr_v_i;
  logic                  instr_ready_o;
  logic                  commit_v_o;
  be_pkg::arch_reg_t     commit_rd_o;
  logic [`BE_WORD_W-1:0] commit_data_o;

  integer seed = 32'h9081_9c1f;

  // architectural model where r0 stays zero
  logic [`BE_WORD_W-1:0] model_rf [`BE_NUM_ARCH_REG];
  be_pkg::arch_reg_t     exp_rd_q [$];
  logic [`BE_WORD_W-1:0] exp_data_q [$];

  int unsigned accept_cnt;
  int unsigned commit_cnt;
  int unsigned stall_cycles;
  int unsigned val_err_cnt;
  int unsigned seq_err_cnt;
  int unsigned cycle_cnt;
  int unsigned mul_burst;
  be_pkg::arch_reg_t     last_rd;
  be_pkg::arch_reg_t     exp_rd;
  logic [`BE_WORD_W-1:0] exp_data;

  be_top u_be_top
  ( .clk_i         (clk_i)
  , .rst_n_i       (rst_n_i)
  , .instr_i       (instr_i)
  , .instr_imm_i   (instr_imm_i)
  , .instr_v_i     (instr_v_i)
  , .instr_ready_o (instr_ready_o)
  , .commit_v_o    (commit_v_o)
  , .commit_rd_o   (commit_rd_o)
  , .commit_data_o (commit_data_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // random instruction with mul bursts and reuse of the last destination
  task automatic make_instr(output be_pkg::instr_u w, output logic is_imm);
    logic [15:0] raw;
    logic [1:0]  op_bits;
    raw     = $random(seed);
    w       = raw;
    op_bits = $random(seed);
    if (mul_burst > 0)
    begin
      op_bits   = 2'd3;
      mul_burst = mul_burst - 1;
    end
    else if (({$random(seed)} % 16) == 0)
    begin
      mul_burst = 6;
    end
    is_imm            = (({$random(seed)} % 3) == 0);
    w.reg_form.op     = be_pkg::op_e'(op_bits);
    w.reg_form.rd     = $random(seed);
    w.reg_form.rs1    = (({$random(seed)} % 3) == 0) ? last_rd
                                                      : be_pkg::arch_reg_t'($random(seed));
    if (!is_imm)
    begin
      w.reg_form.rs2 = (({$random(seed)} % 3) == 0) ? last_rd
                                                     : be_pkg::arch_reg_t'($random(seed));
    end
    last_rd = w.reg_form.rd;
  endtask

  // executes one accepted instruction in program order
  task automatic run_model(input be_pkg::instr_u w, input logic is_imm);
    logic [`BE_WORD_W-1:0] a;
    logic [`BE_WORD_W-1:0] b;
    logic [`BE_WORD_W-1:0] res;
    a = model_rf[w.reg_form.rs1];
    if (is_imm)
    begin
      b = {{(`BE_WORD_W-8){w.imm_form.imm[7]}}, w.imm_form.imm};
    end
    else
    begin
      b = model_rf[w.reg_form.rs2];
    end
    case (w.reg_form.op)
      be_pkg::OP_ADD: res = a + b;
      be_pkg::OP_SUB: res = a - b;
      be_pkg::OP_XOR: res = a ^ b;
      default:        res = a * b;
    endcase
    if (w.reg_form.rd != 0)
    begin
      model_rf[w.reg_form.rd] = res;
    end
    exp_rd_q.push_back(w.reg_form.rd);
    exp_data_q.push_back(res);
    accept_cnt++;
  endtask

  task automatic print_counts();
    $display("errors: %0d value, %0d other; accepted %0d, committed %0d, stall cycles %0d",
             val_err_cnt, seq_err_cnt, accept_cnt, commit_cnt, stall_cycles);
  endtask

  // commit report is registered and stable at the falling edge
  always @(negedge clk_i)
  begin
    if (rst_n_i && commit_v_o)
    begin
      commit_cnt++;
      assert (exp_data_q.size() > 0)
      else
      begin
        seq_err_cnt++;
        $display("a commit at %0t had no accepted instruction left to retire", $time);
      end
      if (exp_data_q.size() > 0)
      begin
        exp_rd   = exp_rd_q.pop_front();
        exp_data = exp_data_q.pop_front();
        assert (commit_rd_o == exp_rd)
        else
        begin
          val_err_cnt++;
          $display("ERR %0t: commit %0d rd %0d, expected %0d",
                   $time, commit_cnt, commit_rd_o, exp_rd);
        end
        assert (commit_data_o == exp_data)
        else
        begin
          val_err_cnt++;
          $display("ERR %0t: commit %0d data %h, expected %h",
                   $time, commit_cnt, commit_data_o, exp_data);
        end
      end
    end
  end

  // watchdog
  initial
  begin
    cycle_cnt = 0;
    wait (rst_n_i === 1'b1);
    while (cycle_cnt < TIMEOUT_CYC)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("the run timed out after %0d cycles with %0d of %0d instructions committed",
             cycle_cnt, commit_cnt, accept_cnt);
    print_counts();
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    be_pkg::instr_u w;
    logic           is_imm;
    rst_n_i      = 1'b0;
    instr_i      = '0;
    instr_imm_i  = 1'b0;
    instr_v_i    = 1'b0;
    accept_cnt   = 0;
    commit_cnt   = 0;
    stall_cycles = 0;
    val_err_cnt  = 0;
    seq_err_cnt  = 0;
    mul_burst    = 0;
    last_rd      = '0;
    for (int i = 0; i < `BE_NUM_ARCH_REG; i++)
    begin
      model_rf[i] = '0;
    end

    // commit stays quiet in reset and just after it
    repeat (8)
    begin
      @(negedge clk_i);
      assert (commit_v_o === 1'b0)
      else
      begin
        seq_err_cnt++;
        $display("commit_v_o was not low during reset at %0t", $time);
      end
    end
    rst_n_i = 1'b1;
    repeat (3)
    begin
      @(negedge clk_i);
      assert (commit_v_o === 1'b0)
      else
      begin
        seq_err_cnt++;
        $display("commit_v_o rose after reset with nothing issued at %0t", $time);
      end
    end

    for (int n = 0; n < N_INSTR; n++)
    begin
      make_instr(w, is_imm);
      if (({$random(seed)} % 10) == 0)
      begin
        @(negedge clk_i);
        instr_v_i = 1'b0;
      end
      @(negedge clk_i);
      instr_i     = w;
      instr_imm_i = is_imm;
      instr_v_i   = 1'b1;
      #1;
      // hold the instruction until ready so it goes in exactly once
      while (!instr_ready_o)
      begin
        stall_cycles++;
        @(negedge clk_i);
        #1;
      end
      run_model(w, is_imm);
    end
    @(negedge clk_i);
    instr_v_i = 1'b0;

    while (commit_cnt < accept_cnt)
    begin
      @(negedge clk_i);
    end
    // extra cycles to catch a duplicated commit
    repeat (10) @(negedge clk_i);

    assert (commit_cnt == accept_cnt)
    else
    begin
      seq_err_cnt++;
      $display("%0d commits were seen for %0d accepted instructions", commit_cnt, accept_cnt);
    end
    assert (stall_cycles > 0)
    else
    begin
      seq_err_cnt++;
      $display("instr_ready_o never went low, so back-pressure was not exercised");
    end

    print_counts();
    if ((val_err_cnt + seq_err_cnt) == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
